//--- hdl/aes_types_pkg.sv
package aes_types_pkg;

    //////////////////////////////
    // Data widths
    //////////////////////////////

    // One state byte
    typedef logic [7:0] byte_t;

    // One column of the state, or one key word
    typedef logic [31:0] word_t;

    // Full state, cipher key or round key
    typedef logic [127:0] block_t;

    //////////////////////////////
    // Round structure
    //////////////////////////////

    // AES-128 uses ten rounds
    parameter int NUM_ROUNDS = 10;

    // Lookup register plus output register
    parameter int ROUND_CYCLES = 2;

    // One cycle for the key addition stage, then the round chain
    parameter int PIPE_LATENCY = 1 + NUM_ROUNDS * ROUND_CYCLES;

    //////////////////////////////
    // Key schedule constants
    //////////////////////////////

    // Powers of x in GF(2^8), one per round
    parameter byte_t RCON [1:NUM_ROUNDS] = '{
        8'h01, 8'h02, 8'h04, 8'h08, 8'h10,
        8'h20, 8'h40, 8'h80, 8'h1b, 8'h36
    };

endpackage

//--- hdl/aes_sbox_pkg.sv
package aes_sbox_pkg;

    import aes_types_pkg::*;

    //////////////////////////////
    // Forward S-box
    //////////////////////////////

    parameter byte_t SBOX [256] = '{
        8'h63, 8'h7c, 8'h77, 8'h7b, 8'hf2, 8'h6b, 8'h6f, 8'hc5,
        8'h30, 8'h01, 8'h67, 8'h2b, 8'hfe, 8'hd7, 8'hab, 8'h76,
        8'hca, 8'h82, 8'hc9, 8'h7d, 8'hfa, 8'h59, 8'h47, 8'hf0,
        8'had, 8'hd4, 8'ha2, 8'haf, 8'h9c, 8'ha4, 8'h72, 8'hc0,
        8'hb7, 8'hfd, 8'h93, 8'h26, 8'h36, 8'h3f, 8'hf7, 8'hcc,
        8'h34, 8'ha5, 8'he5, 8'hf1, 8'h71, 8'hd8, 8'h31, 8'h15,
        8'h04, 8'hc7, 8'h23, 8'hc3, 8'h18, 8'h96, 8'h05, 8'h9a,
        8'h07, 8'h12, 8'h80, 8'he2, 8'heb, 8'h27, 8'hb2, 8'h75,
        8'h09, 8'h83, 8'h2c, 8'h1a, 8'h1b, 8'h6e, 8'h5a, 8'ha0,
        8'h52, 8'h3b, 8'hd6, 8'hb3, 8'h29, 8'he3, 8'h2f, 8'h84,
        8'h53, 8'hd1, 8'h00, 8'hed, 8'h20, 8'hfc, 8'hb1, 8'h5b,
        8'h6a, 8'hcb, 8'hbe, 8'h39, 8'h4a, 8'h4c, 8'h58, 8'hcf,
        8'hd0, 8'hef, 8'haa, 8'hfb, 8'h43, 8'h4d, 8'h33, 8'h85,
        8'h45, 8'hf9, 8'h02, 8'h7f, 8'h50, 8'h3c, 8'h9f, 8'ha8,
        8'h51, 8'ha3, 8'h40, 8'h8f, 8'h92, 8'h9d, 8'h38, 8'hf5,
        8'hbc, 8'hb6, 8'hda, 8'h21, 8'h10, 8'hff, 8'hf3, 8'hd2,
        8'hcd, 8'h0c, 8'h13, 8'hec, 8'h5f, 8'h97, 8'h44, 8'h17,
        8'hc4, 8'ha7, 8'h7e, 8'h3d, 8'h64, 8'h5d, 8'h19, 8'h73,
        8'h60, 8'h81, 8'h4f, 8'hdc, 8'h22, 8'h2a, 8'h90, 8'h88,
        8'h46, 8'hee, 8'hb8, 8'h14, 8'hde, 8'h5e, 8'h0b, 8'hdb,
        8'he0, 8'h32, 8'h3a, 8'h0a, 8'h49, 8'h06, 8'h24, 8'h5c,
        8'hc2, 8'hd3, 8'hac, 8'h62, 8'h91, 8'h95, 8'he4, 8'h79,
        8'he7, 8'hc8, 8'h37, 8'h6d, 8'h8d, 8'hd5, 8'h4e, 8'ha9,
        8'h6c, 8'h56, 8'hf4, 8'hea, 8'h65, 8'h7a, 8'hae, 8'h08,
        8'hba, 8'h78, 8'h25, 8'h2e, 8'h1c, 8'ha6, 8'hb4, 8'hc6,
        8'he8, 8'hdd, 8'h74, 8'h1f, 8'h4b, 8'hbd, 8'h8b, 8'h8a,
        8'h70, 8'h3e, 8'hb5, 8'h66, 8'h48, 8'h03, 8'hf6, 8'h0e,
        8'h61, 8'h35, 8'h57, 8'hb9, 8'h86, 8'hc1, 8'h1d, 8'h9e,
        8'he1, 8'hf8, 8'h98, 8'h11, 8'h69, 8'hd9, 8'h8e, 8'h94,
        8'h9b, 8'h1e, 8'h87, 8'he9, 8'hce, 8'h55, 8'h28, 8'hdf,
        8'h8c, 8'ha1, 8'h89, 8'h0d, 8'hbf, 8'he6, 8'h42, 8'h68,
        8'h41, 8'h99, 8'h2d, 8'h0f, 8'hb0, 8'h54, 8'hbb, 8'h16
    };

    // Multiply by x, reduced by x^8 + x^4 + x^3 + x + 1
    function automatic byte_t xtime(input byte_t b);
        return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
    endfunction

endpackage

//--- hdl/sub_word.sv
`timescale 1ns/1ps

module sub_word (
    input  logic                 clk,
    input  aes_types_pkg::word_t word,
    output aes_types_pkg::word_t subst
);

    import aes_sbox_pkg::*;

    //////////////////////////////
    // Byte substitution
    //////////////////////////////

    // Four independent lookups, one register stage
    always_ff @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            subst[8*i +: 8] <= SBOX[word[8*i +: 8]];
        end
    end

endmodule

//--- hdl/round_lookup.sv
`timescale 1ns/1ps

module round_lookup (
    input  logic                 clk,
    input  aes_types_pkg::word_t column,
    output aes_types_pkg::word_t t0,
    output aes_types_pkg::word_t t1,
    output aes_types_pkg::word_t t2,
    output aes_types_pkg::word_t t3
);

    import aes_types_pkg::*;
    import aes_sbox_pkg::*;

    // Row 0 sits in the top byte of the column
    byte_t sub    [4];
    byte_t sub_q  [4];
    byte_t dbl_q  [4];
    word_t mixed  [4];

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            sub[i] = SBOX[column[8*(3-i) +: 8]];
        end
    end

    //////////////////////////////
    // Lookup registers
    //////////////////////////////

    always_ff @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            sub_q[i] <= sub[i];
            dbl_q[i] <= xtime(sub[i]);
        end
    end

    // MixColumns contribution of one byte, as rows 2 1 1 3
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            mixed[i] = {dbl_q[i], sub_q[i], sub_q[i], dbl_q[i] ^ sub_q[i]};
        end
    end

    //////////////////////////////
    // Row alignment
    //////////////////////////////

    // Byte in row i rotates right by i bytes
    assign t0 = mixed[0];
    assign t1 = {mixed[1][7:0],  mixed[1][31:8]};
    assign t2 = {mixed[2][15:0], mixed[2][31:16]};
    assign t3 = {mixed[3][23:0], mixed[3][31:24]};

endmodule

//--- hdl/cipher_round.sv
`timescale 1ns/1ps

module cipher_round #(
    parameter bit FINAL = 1'b0
) (
    input  logic                  clk,
    input  aes_types_pkg::block_t block_in,
    input  aes_types_pkg::block_t round_key,
    output aes_types_pkg::block_t block_out
);

    import aes_types_pkg::*;

    word_t col [4];
    word_t rk  [4];
    word_t z   [4];

    assign {col[0], col[1], col[2], col[3]} = block_in;
    assign {rk[0], rk[1], rk[2], rk[3]} = round_key;

    //////////////////////////////
    // Substitution and mixing
    //////////////////////////////

    if (!FINAL) begin : g_full
        // Lookup words indexed by source column, then row
        word_t p [4][4];

        for (genvar c = 0; c < 4; c++) begin : g_col
            round_lookup u_lookup (
                .clk    (clk),
                .column (col[c]),
                .t0     (p[c][0]),
                .t1     (p[c][1]),
                .t2     (p[c][2]),
                .t3     (p[c][3])
            );

            // ShiftRows picks row r from column c+r
            assign z[c] = p[c][0] ^ p[(c+1)%4][1] ^ p[(c+2)%4][2] ^ p[(c+3)%4][3]
                        ^ rk[c];
        end
    end else begin : g_final
        // No MixColumns in the last round
        word_t q [4];

        for (genvar c = 0; c < 4; c++) begin : g_col
            sub_word u_sub (
                .clk   (clk),
                .word  (col[c]),
                .subst (q[c])
            );

            assign z[c] = {q[c][31:24], q[(c+1)%4][23:16],
                           q[(c+2)%4][15:8], q[(c+3)%4][7:0]} ^ rk[c];
        end
    end

    // Second stage of the round
    always_ff @(posedge clk) begin
        block_out <= {z[0], z[1], z[2], z[3]};
    end

endmodule

//--- hdl/key_expand_stage.sv
`timescale 1ns/1ps

module key_expand_stage #(
    parameter int ROUND = 1
) (
    input  logic                  clk,
    input  aes_types_pkg::block_t key_in,
    output aes_types_pkg::block_t round_key,
    output aes_types_pkg::block_t key_next
);

    import aes_types_pkg::*;

    word_t k   [4];
    word_t v   [4];
    word_t v_q [4];
    word_t rot_sub;

    assign {k[0], k[1], k[2], k[3]} = key_in;

    //////////////////////////////
    // Prefix xor of key words
    //////////////////////////////

    // Round constant goes into the top byte of word 0
    assign v[0] = k[0] ^ {RCON[ROUND], 24'h000000};
    assign v[1] = v[0] ^ k[1];
    assign v[2] = v[1] ^ k[2];
    assign v[3] = v[2] ^ k[3];

    always_ff @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            v_q[i] <= v[i];
        end
    end

    // RotWord then SubWord, registered in step with v_q
    sub_word u_sub (
        .clk   (clk),
        .word  ({k[3][23:0], k[3][31:24]}),
        .subst (rot_sub)
    );

    //////////////////////////////
    // Round key outputs
    //////////////////////////////

    assign round_key = {v_q[0] ^ rot_sub, v_q[1] ^ rot_sub,
                        v_q[2] ^ rot_sub, v_q[3] ^ rot_sub};

    // Held one more cycle to meet the next round's lookups
    always_ff @(posedge clk) begin
        key_next <= round_key;
    end

endmodule

//--- hdl/aes128_pipeline.sv
`timescale 1ns/1ps

module aes128_pipeline (
    input  logic                  clk,
    input  aes_types_pkg::block_t plaintext,
    input  aes_types_pkg::block_t key,
    output aes_types_pkg::block_t ciphertext
);

    import aes_types_pkg::*;

    block_t state_q;
    block_t key_q;

    // Index 0 is the key addition stage
    block_t state_chain [NUM_ROUNDS+1];
    block_t key_chain   [NUM_ROUNDS];
    block_t round_keys  [NUM_ROUNDS];

    //////////////////////////////
    // Initial key addition
    //////////////////////////////

    // New pair taken on every edge
    always_ff @(posedge clk) begin
        state_q <= plaintext ^ key;
        key_q   <= key;
    end

    assign state_chain[0] = state_q;
    assign key_chain[0]   = key_q;

    //////////////////////////////
    // Key schedule and rounds
    //////////////////////////////

    for (genvar r = 0; r < NUM_ROUNDS; r++) begin : g_round
        if (r < NUM_ROUNDS - 1) begin : g_key
            key_expand_stage #(
                .ROUND (r + 1)
            ) u_key (
                .clk       (clk),
                .key_in    (key_chain[r]),
                .round_key (round_keys[r]),
                .key_next  (key_chain[r+1])
            );
        end else begin : g_key_last
            // Last round key feeds no further stage
            key_expand_stage #(
                .ROUND (r + 1)
            ) u_key (
                .clk       (clk),
                .key_in    (key_chain[r]),
                .round_key (round_keys[r]),
                .key_next  ()
            );
        end

        // Last round skips MixColumns
        cipher_round #(
            .FINAL (r == NUM_ROUNDS - 1)
        ) u_round (
            .clk       (clk),
            .block_in  (state_chain[r]),
            .round_key (round_keys[r]),
            .block_out (state_chain[r+1])
        );
    end

    assign ciphertext = state_chain[NUM_ROUNDS];

endmodule

//--- verif/aes128_model.svh
`ifndef AES128_MODEL_SVH
`define AES128_MODEL_SVH

//////////////////////////////
// Field and state helpers
//////////////////////////////

// Doubling in GF(2^8), reduced by 0x11b
function automatic byte_t gf_double(input byte_t b);
    byte_t d;
    d = b << 1;
    if (b[7]) begin
        d = d ^ 8'h1b;
    end
    return d;
endfunction

// Row r of column c; columns fill from the top byte down
function automatic byte_t byte_at(input block_t s, input int r, input int c);
    return s[127 - 8*(4*c + r) -: 8];
endfunction

function automatic block_t sub_bytes(input block_t s);
    block_t o;
    for (int i = 0; i < 16; i++) begin
        o[8*i +: 8] = SBOX[s[8*i +: 8]];
    end
    return o;
endfunction

// Row r moves left by r columns
function automatic block_t shift_rows(input block_t s);
    block_t o;
    for (int c = 0; c < 4; c++) begin
        for (int r = 0; r < 4; r++) begin
            o[127 - 8*(4*c + r) -: 8] = byte_at(s, r, (c + r) % 4);
        end
    end
    return o;
endfunction

function automatic block_t mix_columns(input block_t s);
    block_t o;
    byte_t  a [4];
    byte_t  d [4];
    for (int c = 0; c < 4; c++) begin
        for (int r = 0; r < 4; r++) begin
            a[r] = byte_at(s, r, c);
            d[r] = gf_double(a[r]);
        end
        // Circulant matrix 2 3 1 1, with 3a written as 2a ^ a
        o[127 - 32*c -: 32] = {d[0] ^ d[1] ^ a[1] ^ a[2] ^ a[3],
                               a[0] ^ d[1] ^ d[2] ^ a[2] ^ a[3],
                               a[0] ^ a[1] ^ d[2] ^ d[3] ^ a[3],
                               d[0] ^ a[0] ^ a[1] ^ a[2] ^ d[3]};
    end
    return o;
endfunction

//////////////////////////////
// Key schedule and cipher
//////////////////////////////

function automatic block_t next_round_key(input block_t k, input byte_t rcon);
    word_t w [4];
    word_t t;
    for (int i = 0; i < 4; i++) begin
        w[i] = k[127 - 32*i -: 32];
    end
    // RotWord, then SubWord, then the round constant
    t = {w[3][23:0], w[3][31:24]};
    for (int i = 0; i < 4; i++) begin
        t[8*i +: 8] = SBOX[t[8*i +: 8]];
    end
    t = t ^ {rcon, 24'h000000};
    w[0] = w[0] ^ t;
    w[1] = w[1] ^ w[0];
    w[2] = w[2] ^ w[1];
    w[3] = w[3] ^ w[2];
    return {w[0], w[1], w[2], w[3]};
endfunction

function automatic block_t aes128_encrypt(input block_t pt, input block_t k);
    block_t s;
    block_t rk;
    byte_t  rcon;
    s    = pt ^ k;
    rk   = k;
    rcon = 8'h01;
    for (int r = 1; r <= 10; r++) begin
        rk   = next_round_key(rk, rcon);
        rcon = gf_double(rcon);
        s    = shift_rows(sub_bytes(s));
        // Last round has no MixColumns
        if (r < 10) begin
            s = mix_columns(s);
        end
        s = s ^ rk;
    end
    return s;
endfunction

// 32-bit xorshift step, shifts 13 17 5
function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
endfunction

`endif

//--- verif/aes128_tb.sv
`timescale 1ns/1ps

module aes128_tb;

    import aes_types_pkg::*;
    import aes_sbox_pkg::*;

    `include "aes128_model.svh"

    localparam int HOLD_CYCLES = 30;
    localparam int NUM_STREAM  = 64;
    localparam int NUM_AGILE   = 32;
    localparam int MARGIN      = 40;
    localparam logic [31:0] SEED = 32'd49;

    // Cycles spent by reset and each test, in run order
    localparam int TEST_CYCLES = 2
        + 2 * (PIPE_LATENCY + 1)
        + (HOLD_CYCLES + PIPE_LATENCY + 5)
        + (NUM_STREAM + PIPE_LATENCY)
        + (NUM_AGILE + PIPE_LATENCY)
        + 2;
    localparam int TIMEOUT_CYCLES = TEST_CYCLES + PIPE_LATENCY + MARGIN;

    logic   clk = 1'b0;
    logic   rst;
    block_t plaintext;
    block_t key;
    block_t ciphertext;

    int          checks       = 0;
    int          block_errors = 0;
    int          count_errors = 0;
    int          cycle_count  = 0;
    logic [31:0] rng_state;

    aes128_pipeline UUT (
        .clk        (clk),
        .plaintext  (plaintext),
        .key        (key),
        .ciphertext (ciphertext)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display(">>> FAIL");
            $finish;
        end
    end

    //////////////////////////////
    // Compare and stimulus helpers
    //////////////////////////////

    task automatic check_block(input string name, input block_t expected,
                               input block_t actual);
        checks++;
        if (actual !== expected) begin
            block_errors++;
            $display("Error: %s expected %h got %h (cycle %0d)",
                     name, expected, actual, cycle_count);
        end
    endtask

    task automatic check_count(input string name, input int expected, input int actual);
        checks++;
        if (actual !== expected) begin
            count_errors++;
            $display("Error: %s expected %0h got %0h", name, expected, actual);
        end
    endtask

    function automatic block_t random_block();
        block_t b;
        for (int i = 0; i < 4; i++) begin
            rng_state = xorshift32(rng_state);
            b[32*i +: 32] = rng_state;
        end
        return b;
    endfunction

    // One pair in, result read PIPE_LATENCY edges after it is driven
    task automatic run_known_answer(input block_t pt, input block_t k,
                                    input block_t expected);
        check_block("model", expected, aes128_encrypt(pt, k));
        @(posedge clk);
        plaintext <= pt;
        key       <= k;
        repeat (PIPE_LATENCY) @(posedge clk);
        @(negedge clk);
        check_block("ciphertext", expected, ciphertext);
    endtask

    // Back to back pairs; the check for pair j runs PIPE_LATENCY edges after it
    task automatic stream_blocks(input int count, input bit fixed_text,
                                 input block_t text);
        block_t pts      [$];
        block_t keys     [$];
        block_t expected [$];
        block_t pt;
        block_t k;
        for (int i = 0; i < count; i++) begin
            pt = fixed_text ? text : random_block();
            k  = random_block();
            pts.push_back(pt);
            keys.push_back(k);
            expected.push_back(aes128_encrypt(pt, k));
        end
        for (int c = 0; c < count + PIPE_LATENCY; c++) begin
            @(posedge clk);
            if (c < count) begin
                plaintext <= pts[c];
                key       <= keys[c];
            end
            @(negedge clk);
            if (c >= PIPE_LATENCY) begin
                check_block("ciphertext", expected[c - PIPE_LATENCY], ciphertext);
            end
        end
    endtask

    //////////////////////////////
    // Directed tests
    //////////////////////////////

    task automatic fips_appendix_b();
        run_known_answer(128'h3243f6a8885a308d313198a2e0370734,
                         128'h2b7e151628aed2a6abf7158809cf4f3c,
                         128'h3925841d02dc09fbdc118597196a0b32);
    endtask

    task automatic fips_appendix_c();
        run_known_answer(128'h00112233445566778899aabbccddeeff,
                         128'h000102030405060708090a0b0c0d0e0f,
                         128'h69c4e0d86a7b0430d8cdb78070b4c55a);
    endtask

    task automatic switch_latency();
        block_t pt_a;
        block_t key_a;
        block_t pt_b;
        block_t key_b;
        block_t res_a;
        block_t res_b;
        int     latency;
        pt_a  = random_block();
        key_a = random_block();
        pt_b  = random_block();
        key_b = random_block();
        res_a = aes128_encrypt(pt_a, key_a);
        res_b = aes128_encrypt(pt_b, key_b);
        @(posedge clk);
        plaintext <= pt_a;
        key       <= key_a;
        repeat (HOLD_CYCLES - 1) @(posedge clk);
        @(negedge clk);
        check_block("ciphertext", res_a, ciphertext);
        @(posedge clk);
        plaintext <= pt_b;
        key       <= key_b;
        latency = -1;
        // Old result must hold until the new one arrives
        for (int c = 1; c <= PIPE_LATENCY + 4; c++) begin
            @(posedge clk);
            @(negedge clk);
            if (ciphertext == res_b) begin
                latency = c;
                break;
            end
            check_block("ciphertext", res_a, ciphertext);
        end
        check_count("latency", PIPE_LATENCY, latency);
    endtask

    task automatic random_stream();
        stream_blocks(NUM_STREAM, 1'b0, '0);
    endtask

    // Same text, new key each cycle
    task automatic key_agility();
        stream_blocks(NUM_AGILE, 1'b1, 128'h00112233445566778899aabbccddeeff);
    endtask

    initial begin
        rst       <= 1'b1;
        plaintext <= '0;
        key       <= '0;
        rng_state = SEED;
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        fips_appendix_b();
        fips_appendix_c();
        switch_latency();
        random_stream();
        key_agility();

        repeat (2) @(posedge clk);
        $display("Checks: %0d, ciphertext errors: %0d, latency errors: %0d",
                 checks, block_errors, count_errors);
        if (block_errors + count_errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

//--- files.f
+incdir+verif
hdl/aes_types_pkg.sv
hdl/aes_sbox_pkg.sv
hdl/sub_word.sv
hdl/round_lookup.sv
hdl/cipher_round.sv
hdl/key_expand_stage.sv
hdl/aes128_pipeline.sv
verif/aes128_tb.sv

//--- Makefile
# Verilator flow for the AES-128 pipeline
# Override any variable on the command line, e.g. make sim OBJ_DIR=build

VERILATOR  ?= verilator
FILE_LIST  ?= files.f
TB_TOP     ?= aes128_tb
RTL_TOP    ?= aes128_pipeline
OBJ_DIR    ?= obj_dir
BUILD_JOBS ?= 4
VFLAGS     ?= --timing
LINT_FLAGS ?= --lint-only

# RTL sources are the hdl/ entries of the file list, in order
RTL_SRCS = $(shell grep '^hdl/' $(FILE_LIST))

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

build:
	$(VERILATOR) --binary $(VFLAGS) -j $(BUILD_JOBS) --top-module $(TB_TOP) \
		-Mdir $(OBJ_DIR) -f $(FILE_LIST)

# Exit status follows the search for the pass line
sim: build
	@out="$$(./$(OBJ_DIR)/V$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF '>>> PASS'

clean:
	rm -rf $(OBJ_DIR)
